// File: logic/pad_settings.svh
// Pad bridge constants for widths, port count and mouse timeout, included wherever used
`ifndef PAD_SETTINGS_SVH
`define PAD_SETTINGS_SVH

// ============================================================
// Pad bus geometry
// ============================================================
`define PAD_PORTS         5        // Multitap ports
`define PAD_PORT_BITS     3        // Tap index, counts past the last port
`define PAD_HOST_BITS     12       // Host joystick word
`define PAD_WORD_BITS     16       // Four nibbles per port
`define PAD_NIBBLE_BITS   4

// Read back from a tap slot with nothing plugged in
`define PAD_IDLE_WORD     16'h0FFF

// ============================================================
// Mouse
// ============================================================
`define PAD_MOUSE_BITS    8        // Motion per axis
`define PAD_TIMEOUT_BITS  15
`define PAD_MOUSE_TIMEOUT 32767    // Clear-low cycles before the nibble sequence rewinds

`endif

// File: logic/pad_pkg.sv
// Shared pad bridge types, referenced by scoped name from the RTL and the testbench
`include "pad_settings.svh"

package pad_pkg;

	// Host joystick word, buttons active high
	// bits 3:0  up down left right (3..0)
	// bits 7:4  run select II I
	// bits 11:8 VI V IV III
	typedef logic [`PAD_HOST_BITS-1:0] host_pad_t;

	// Console pad word, active low, four nibbles
	// n0 buttons, n1 directions, n2 extra buttons, n3 always 0
	typedef logic [`PAD_WORD_BITS-1:0] pad_word_t;

	typedef logic [`PAD_PORT_BITS-1:0] pad_port_t;     // Tap port index

	typedef logic [`PAD_NIBBLE_BITS-1:0] pad_nibble_t; // Value on the pad bus

	// Which half of the mouse motion goes out next
	typedef enum logic [1:0] {
		mouse_x_hi = 2'd0,
		mouse_x_lo = 2'd1,
		mouse_y_hi = 2'd2,
		mouse_y_lo = 2'd3
	} mouse_phase_e;

endpackage

// File: logic/pad_host_if.sv
// Captured host state, from the capture block to the scan controller and the output stage
`timescale 1ns/1ns
`include "pad_settings.svh"

interface pad_host_if;

	pad_pkg::pad_word_t [`PAD_PORTS-1:0] pads; // After the player swap
	pad_pkg::pad_nibble_t mouse_btn_nibble;
	logic [`PAD_MOUSE_BITS-1:0] mouse_dx;      // X already negated
	logic [`PAD_MOUSE_BITS-1:0] mouse_dy;
	logic frame_take;                          // Snapshot taken, clear totals

	modport capture (
		output pads,
		output mouse_btn_nibble,
		output mouse_dx,
		output mouse_dy,
		input  frame_take
	);

	modport ctrl (
		input  mouse_dx,
		input  mouse_dy,
		output frame_take
	);

	modport out (
		input  pads,
		input  mouse_btn_nibble
	);

endinterface

// File: logic/pad_scan_if.sv
// Scan state from the strobe sequencer to the pad bus output stage
`timescale 1ns/1ns
`include "pad_settings.svh"

interface pad_scan_if;

	pad_pkg::pad_port_t tap_port;      // Current multitap slot
	logic high_bank;                   // Six-button upper bank
	pad_pkg::mouse_phase_e mouse_phase;
	logic [`PAD_MOUSE_BITS-1:0] frame_x;
	logic [`PAD_MOUSE_BITS-1:0] frame_y;
	logic clr;                         // Strobes as seen on the bus
	logic sel;

	modport ctrl (
		output tap_port,
		output high_bank,
		output mouse_phase,
		output frame_x,
		output frame_y,
		output clr,
		output sel
	);

	modport out (
		input  tap_port,
		input  high_bank,
		input  mouse_phase,
		input  frame_x,
		input  frame_y,
		input  clr,
		input  sel
	);

endinterface

// File: logic/host_pad_capture.sv
// Input side of the pad bridge: swaps and maps host joysticks, accumulates mouse motion
`timescale 1ns/1ns
`include "pad_settings.svh"

module host_pad_capture (
	input  logic clk_sys,
	input  logic arst_n,
	input  pad_pkg::host_pad_t [`PAD_PORTS-1:0] joy,
	input  logic joy_swap,
	input  logic mouse_valid,
	input  logic [`PAD_MOUSE_BITS-1:0] mouse_x,
	input  logic [`PAD_MOUSE_BITS-1:0] mouse_y,
	input  logic [1:0] mouse_btn,      // 1 right, 0 left
	pad_host_if.capture host
);

	// Host layout to console layout, inverted
	function automatic pad_pkg::pad_word_t to_pad_word(input pad_pkg::host_pad_t j);
		return ~{4'hF, j[11:8], j[1], j[2], j[0], j[3], j[7:4]};
	endfunction

	pad_pkg::host_pad_t [`PAD_PORTS-1:0] joy_sw;
	logic [`PAD_MOUSE_BITS-1:0] base_x;
	logic [`PAD_MOUSE_BITS-1:0] base_y;

	// ============================================================
	// Joysticks
	// ============================================================
	always_comb begin
		joy_sw = joy;
		if (joy_swap) begin
			joy_sw[0] = joy[1];
			joy_sw[1] = joy[0];
		end
	end

	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < `PAD_PORTS; i++) begin
			host.pads[i] <= to_pad_word(joy_sw[i]);
		end
		// Player one run/select ride along with the mouse buttons
		host.mouse_btn_nibble <= ~{joy_sw[0][7:6], mouse_btn[1], mouse_btn[0]};
	end

	// ============================================================
	// Mouse motion totals
	// ============================================================
	// Frame snapshot restarts the totals, a sample in the same cycle still counts
	assign base_x = host.frame_take ? '0 : host.mouse_dx;
	assign base_y = host.frame_take ? '0 : host.mouse_dy;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			host.mouse_dx <= '0;
			host.mouse_dy <= '0;
		end else if (mouse_valid) begin
			host.mouse_dx <= base_x - mouse_x;  // Console X runs the other way
			host.mouse_dy <= base_y + mouse_y;
		end else if (host.frame_take) begin
			host.mouse_dx <= '0;
			host.mouse_dy <= '0;
		end
	end

endmodule

// File: logic/pad_scan_ctrl.sv
// Strobe sequencer: follows select and clear to track tap port, button bank and mouse phase
`timescale 1ns/1ns
`include "pad_settings.svh"

module pad_scan_ctrl (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic pad_sel,
	input  logic pad_clr,
	input  logic turbotap,
	input  logic buttons6,
	pad_host_if.ctrl host,
	pad_scan_if.ctrl scan
);

	logic sel_q;
	logic sel_qq;
	logic clr_q;
	logic clr_qq;
	logic sel_rise;
	logic clr_rise;
	logic timed_out;
	logic [`PAD_TIMEOUT_BITS-1:0] to_cnt;

	// Output stage sees the strobes directly
	assign scan.sel = pad_sel;
	assign scan.clr = pad_clr;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sel_q  <= 1'b0;
			sel_qq <= 1'b0;
			clr_q  <= 1'b0;
			clr_qq <= 1'b0;
		end else begin
			sel_q  <= pad_sel;
			sel_qq <= sel_q;
			clr_q  <= pad_clr;
			clr_qq <= clr_q;
		end
	end

	assign sel_rise = sel_q & ~sel_qq;
	assign clr_rise = clr_q & ~clr_qq;

	// Start of a new mouse packet
	assign host.frame_take = clr_rise && (scan.mouse_phase == pad_pkg::mouse_y_lo);

	// ============================================================
	// Mouse timeout, counts while clear stays low
	// ============================================================
	assign timed_out = (to_cnt == `PAD_TIMEOUT_BITS'(`PAD_MOUSE_TIMEOUT));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			to_cnt <= '0;
		end else if (clr_q) begin
			to_cnt <= '0;
		end else if (!timed_out) begin
			to_cnt <= to_cnt + 1'b1;  // Sticks at the limit
		end
	end

	// ============================================================
	// Scan state
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			scan.tap_port    <= '0;
			scan.high_bank   <= 1'b0;
			scan.mouse_phase <= pad_pkg::mouse_y_lo;  // First clear starts at X high
			scan.frame_x     <= '0;
			scan.frame_y     <= '0;
		end else begin
			if (clr_rise) begin
				scan.tap_port    <= '0;
				scan.high_bank   <= buttons6 & ~scan.high_bank;
				scan.mouse_phase <= pad_pkg::mouse_phase_e'(scan.mouse_phase + 2'd1);
			end else begin
				if (timed_out)
					scan.mouse_phase <= pad_pkg::mouse_y_lo;
				if (sel_rise && turbotap && !clr_q && scan.tap_port != '1)
					scan.tap_port <= scan.tap_port + 1'b1;
			end
			if (host.frame_take) begin
				scan.frame_x <= host.mouse_dx;
				scan.frame_y <= host.mouse_dy;
			end
		end
	end

	// Without the multitap the bus never leaves port 0
	tap_idle_a: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(!turbotap && scan.tap_port == '0) |=> (scan.tap_port == '0));

	// One snapshot per clear edge
	frame_take_a: assert property (@(posedge clk_sys) disable iff (!arst_n)
		host.frame_take |=> !host.frame_take);

endmodule

// File: logic/pad_nibble_out.sv
// Output stage: picks the port word and nibble and registers the 4-bit pad bus
`timescale 1ns/1ns
`include "pad_settings.svh"

module pad_nibble_out (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic mouse_en,
	pad_scan_if.out scan,
	pad_host_if.out host,
	output pad_pkg::pad_nibble_t pad_nibble
);

	pad_pkg::pad_nibble_t mouse_hi;
	pad_pkg::pad_word_t port_word;
	logic [1:0] nib_idx;

	// Motion half for this phase
	always_comb begin
		case (scan.mouse_phase)
			pad_pkg::mouse_x_hi: mouse_hi = scan.frame_x[7:4];
			pad_pkg::mouse_x_lo: mouse_hi = scan.frame_x[3:0];
			pad_pkg::mouse_y_hi: mouse_hi = scan.frame_y[7:4];
			default:             mouse_hi = scan.frame_y[3:0];
		endcase
	end

	// ============================================================
	// Port word select
	// ============================================================
	always_comb begin
		if (scan.tap_port == '0 && mouse_en)
			port_word = {2{mouse_hi, host.mouse_btn_nibble}};  // Mouse sits on port 0
		else if (scan.tap_port < `PAD_PORTS)
			port_word = host.pads[scan.tap_port];
		else
			port_word = `PAD_IDLE_WORD;  // Past the last pad
	end

	assign nib_idx = {scan.high_bank, scan.sel};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pad_nibble <= '0;
		end else if (scan.clr) begin
			pad_nibble <= '0;  // Bus reads all pressed during clear
		end else begin
			pad_nibble <= port_word[{nib_idx, 2'b00} +: `PAD_NIBBLE_BITS];
		end
	end

endmodule

// File: logic/pad_port_top.sv
// Controller port bridge top level: host pads and mouse in, console pad bus out
`timescale 1ns/1ns
`include "pad_settings.svh"

module pad_port_top (
	input  logic clk_sys,
	input  logic arst_n,
	input  pad_pkg::host_pad_t joy_0,
	input  pad_pkg::host_pad_t joy_1,
	input  pad_pkg::host_pad_t joy_2,
	input  pad_pkg::host_pad_t joy_3,
	input  pad_pkg::host_pad_t joy_4,
	input  logic joy_swap,
	input  logic turbotap,
	input  logic buttons6,
	input  logic mouse_en,
	input  logic mouse_valid,
	input  logic [`PAD_MOUSE_BITS-1:0] mouse_x,
	input  logic [`PAD_MOUSE_BITS-1:0] mouse_y,
	input  logic [1:0] mouse_btn,
	input  logic pad_sel,
	input  logic pad_clr,
	output pad_pkg::pad_nibble_t pad_nibble
);

	pad_host_if host_bus ();
	pad_scan_if scan_bus ();

	host_pad_capture i_host_pad_capture (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.joy         ({joy_4, joy_3, joy_2, joy_1, joy_0}),
		.joy_swap    (joy_swap),
		.mouse_valid (mouse_valid),
		.mouse_x     (mouse_x),
		.mouse_y     (mouse_y),
		.mouse_btn   (mouse_btn),
		.host        (host_bus.capture)
	);

	pad_scan_ctrl i_pad_scan_ctrl (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.pad_sel  (pad_sel),
		.pad_clr  (pad_clr),
		.turbotap (turbotap),
		.buttons6 (buttons6),
		.host     (host_bus.ctrl),
		.scan     (scan_bus.ctrl)
	);

	pad_nibble_out i_pad_nibble_out (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.mouse_en   (mouse_en),
		.scan       (scan_bus.out),
		.host       (host_bus.out),
		.pad_nibble (pad_nibble)
	);

endmodule

// File: tests/tb_clock.sv
// Clock and power-on reset source for the pad bridge testbench, instantiated by its top module
`timescale 1ns/1ns

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	localparam int HALF_NS = 2;  // 4 ns period

	initial begin
		clk_sys = 1'b0;
		forever #HALF_NS clk_sys = ~clk_sys;
	end

	// Reset held for two clock cycles
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

// File: tests/tb_pad_port.sv
// Directed testbench for the pad bridge, drives sticks, mouse and strobes and checks the pad bus
`timescale 1ns/1ns
`include "pad_settings.svh"

module tb_pad_port;

	localparam int CLK_NS      = 4;
	localparam int TEST_CYCLES = 6 * 400;  // Directed tests, with slack
	localparam int WATCHDOG_NS = (TEST_CYCLES + `PAD_MOUSE_TIMEOUT + 1000) * CLK_NS;

	logic clk_sys;
	logic arst_n;
	pad_pkg::host_pad_t joy [`PAD_PORTS];
	logic joy_swap;
	logic turbotap;
	logic buttons6;
	logic mouse_en;
	logic mouse_valid;
	logic [7:0] mouse_x;
	logic [7:0] mouse_y;
	logic [1:0] mouse_btn;
	logic pad_sel;
	logic pad_clr;
	pad_pkg::pad_nibble_t pad_nibble;

	integer seed = 63183;
	int errors = 0;
	int checks = 0;
	int test_base = 0;
	int clr_count = 0;     // Clear edges since the mouse sequence last sat at y low
	logic [7:0] acc_x = '0;  // Expected motion totals, x mirrored
	logic [7:0] acc_y = '0;
	logic [7:0] frm_x = '0;  // Totals latched at the start of a packet
	logic [7:0] frm_y = '0;

	tb_clock i_tb_clock (.clk_sys(clk_sys), .arst_n(arst_n));

	pad_port_top i_pad_port_top (
		.clk_sys(clk_sys), .arst_n(arst_n),
		.joy_0(joy[0]), .joy_1(joy[1]), .joy_2(joy[2]), .joy_3(joy[3]), .joy_4(joy[4]),
		.joy_swap(joy_swap), .turbotap(turbotap), .buttons6(buttons6), .mouse_en(mouse_en),
		.mouse_valid(mouse_valid), .mouse_x(mouse_x), .mouse_y(mouse_y),
		.mouse_btn(mouse_btn), .pad_sel(pad_sel), .pad_clr(pad_clr), .pad_nibble(pad_nibble)
	);

	// ============================================================
	// Reference model and helpers
	// ============================================================
	function automatic pad_pkg::pad_word_t console_word(input pad_pkg::host_pad_t j);
		pad_pkg::pad_nibble_t btn;
		pad_pkg::pad_nibble_t dir;
		pad_pkg::pad_nibble_t ext;
		btn = ~{j[7], j[6], j[5], j[4]};    // run select II I
		dir = ~{j[1], j[2], j[0], j[3]};    // left down right up
		ext = ~{j[11], j[10], j[9], j[8]};  // VI V IV III
		return {4'h0, ext, dir, btn};
	endfunction

	function automatic pad_pkg::pad_nibble_t nibble_of(input pad_pkg::pad_word_t w, input int idx);
		return w[idx*4 +: 4];
	endfunction

	function automatic pad_pkg::pad_nibble_t motion_nibble(input int phase);
		case (phase)
			0: return frm_x[7:4];
			1: return frm_x[3:0];
			2: return frm_y[7:4];
			default: return frm_y[3:0];
		endcase
	endfunction

	task automatic check_nibble(input pad_pkg::pad_nibble_t exp, input string what);
		checks++;
		if (pad_nibble !== exp) begin
			errors++;
			$display("Error at %0t ns: %s read %h, expected %h", $time, what, pad_nibble, exp);
		end
	endtask

	// Strobes change on a rising edge, read back once the scan state has settled
	task automatic drive_strobes(input logic sel, input logic clr);
		@(posedge clk_sys);
		pad_sel <= sel;
		pad_clr <= clr;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic pulse_clear();
		drive_strobes(1'b0, 1'b1);
		check_nibble(4'h0, "bus during clear");
		if (clr_count % 4 == 0) begin  // New mouse packet latches the totals
			frm_x = acc_x;
			frm_y = acc_y;
			acc_x = '0;
			acc_y = '0;
		end
		clr_count++;
		drive_strobes(1'b0, 1'b0);
	endtask

	task automatic send_motion(input logic [7:0] x, input logic [7:0] y);
		@(posedge clk_sys);
		mouse_valid <= 1'b1;
		mouse_x <= x;
		mouse_y <= y;
		@(posedge clk_sys);
		mouse_valid <= 1'b0;
		acc_x = acc_x - x;
		acc_y = acc_y + y;
	endtask

	task automatic randomize_sticks();
		int r;
		@(posedge clk_sys);
		for (int i = 0; i < `PAD_PORTS; i++) begin
			r = $random(seed);
			joy[i] <= r[11:0];
		end
		@(negedge clk_sys);
	endtask

	task automatic report_test(input string name);
		$display("%-10s %s, %0d errors", name, (errors == test_base) ? "ok" : "mismatch",
			errors - test_base);
		test_base = errors;
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic test_single();
		pulse_clear();
		check_nibble(nibble_of(console_word(joy[0]), 0), "port 0 buttons");
		drive_strobes(1'b1, 1'b0);
		check_nibble(nibble_of(console_word(joy[0]), 1), "port 0 directions");
		report_test("single");
	endtask

	task automatic test_swap();
		@(posedge clk_sys);
		joy_swap <= 1'b1;
		pulse_clear();
		check_nibble(nibble_of(console_word(joy[1]), 0), "swapped port 0 buttons");
		drive_strobes(1'b1, 1'b0);
		check_nibble(nibble_of(console_word(joy[1]), 1), "swapped port 0 directions");
		@(posedge clk_sys);
		turbotap <= 1'b1;
		pulse_clear();
		drive_strobes(1'b1, 1'b0);  // Tap moves to port 1
		check_nibble(nibble_of(console_word(joy[0]), 1), "swapped port 1 directions");
		drive_strobes(1'b0, 1'b0);
		check_nibble(nibble_of(console_word(joy[0]), 0), "swapped port 1 buttons");
		@(posedge clk_sys);
		joy_swap <= 1'b0;
		turbotap <= 1'b0;
		report_test("swap");
	endtask

	task automatic test_multitap();
		pad_pkg::pad_word_t w;
		@(posedge clk_sys);
		turbotap <= 1'b1;
		pulse_clear();
		check_nibble(nibble_of(console_word(joy[0]), 0), "tap port 0 buttons");
		for (int k = 1; k < 9; k++) begin  // Last pass checks the saturated port
			w = (k < `PAD_PORTS) ? console_word(joy[k]) : `PAD_IDLE_WORD;
			drive_strobes(1'b1, 1'b0);
			check_nibble(nibble_of(w, 1), $sformatf("tap step %0d directions", k));
			drive_strobes(1'b0, 1'b0);
			check_nibble(nibble_of(w, 0), $sformatf("tap step %0d buttons", k));
		end
		@(posedge clk_sys);
		turbotap <= 1'b0;
		pulse_clear();
		report_test("multitap");
	endtask

	task automatic test_six_button();
		@(posedge clk_sys);
		buttons6 <= 1'b1;
		pulse_clear();  // Bank flips to the upper pair
		check_nibble(nibble_of(console_word(joy[0]), 2), "bank 2 extra buttons");
		drive_strobes(1'b1, 1'b0);
		check_nibble(4'h0, "bank 3");
		pulse_clear();
		check_nibble(nibble_of(console_word(joy[0]), 0), "bank 0 buttons");
		drive_strobes(1'b1, 1'b0);
		check_nibble(nibble_of(console_word(joy[0]), 1), "bank 1 directions");
		@(posedge clk_sys);
		buttons6 <= 1'b0;
		report_test("six_button");
	endtask

	task automatic test_mouse();
		int r;
		pad_pkg::pad_nibble_t btn_nib;
		@(posedge clk_sys);
		mouse_en <= 1'b1;
		mouse_btn <= 2'b01;
		while (clr_count % 4 != 0)
			pulse_clear();  // Next clear opens a packet
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			send_motion(r[7:0], r[15:8]);
		end
		btn_nib = ~{joy[0][7], joy[0][6], mouse_btn[1], mouse_btn[0]};
		for (int p = 0; p < 4; p++) begin
			pulse_clear();
			check_nibble(btn_nib, "mouse buttons");
			drive_strobes(1'b1, 1'b0);
			check_nibble(motion_nibble(p), $sformatf("mouse motion phase %0d", p));
			if (p == 0) begin
				r = $random(seed);
				send_motion(r[7:0], r[15:8]);  // Belongs to the next packet
			end
		end
		report_test("mouse");
	endtask

	task automatic test_timeout();
		pulse_clear();
		send_motion(8'h21, 8'h5A);
		repeat (`PAD_MOUSE_TIMEOUT + 16) @(posedge clk_sys);
		clr_count = 0;  // Sequence rewound to y low
		pulse_clear();
		drive_strobes(1'b1, 1'b0);
		check_nibble(motion_nibble(0), "x high after timeout");
		@(posedge clk_sys);
		mouse_en <= 1'b0;
		report_test("timeout");
	endtask

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		for (int i = 0; i < `PAD_PORTS; i++)
			joy[i] <= '0;
		joy_swap <= 1'b0;
		turbotap <= 1'b0;
		buttons6 <= 1'b0;
		mouse_en <= 1'b0;
		mouse_valid <= 1'b0;
		mouse_x <= '0;
		mouse_y <= '0;
		mouse_btn <= '0;
		pad_sel <= 1'b0;
		pad_clr <= 1'b0;
		@(posedge arst_n);
		@(negedge clk_sys);
		check_nibble(4'h0, "bus after reset");
		report_test("reset");
		randomize_sticks();
		test_single();
		test_swap();
		test_multitap();
		test_six_button();
		test_mouse();
		test_timeout();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: project.f
+incdir+logic
logic/pad_pkg.sv
logic/pad_host_if.sv
logic/pad_scan_if.sv
logic/host_pad_capture.sv
logic/pad_scan_ctrl.sv
logic/pad_nibble_out.sv
logic/pad_port_top.sv
tests/tb_clock.sv
tests/tb_pad_port.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_pad_port
FILELIST = project.f
LOG      = sim.log
PASS_MSG = *** PASSED ***

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
